// File: Bender.yml
package:
  name: crypto_duplex

sources:
  - crypto_pkg.sv
  - duplex_if.sv
  - duplex_absorb.sv
  - duplex_round.sv
  - duplex_squeeze.sv
  - mem_walker.sv
  - crypto_control.sv
  - crypto_top.sv
  - target: simulation
    files:
      - tb_crypto.sv

// File: crypto_control.sv
`timescale 1ns/10ps
`default_nettype none

module crypto_control import crypto_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  logic   cmd_wrap,
    input  logic   cmd_verify,
    input  word_t  mem_in,
    input  logic   mem_done,
    duplex_if.ctrl eng,
    output logic   busy,
    output logic   reg_write,
    output logic   mb_en,
    output logic   mb_wr,
    output word_t  data_out,
    output logic   text_init,
    output logic   tag_init,
    output logic   ctr_inc,
    output logic   cipher_inc,
    output logic   select_cipher
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        is_wrap;
    logic        issue;
    duplex_op_t  issue_op;

    always_comb
    begin
        next_state    = state;
        busy          = 1'b1;
        reg_write     = 1'b0;
        mb_en         = 1'b0;
        mb_wr         = 1'b0;
        data_out      = '0;
        text_init     = 1'b0;
        tag_init      = 1'b0;
        ctr_inc       = 1'b0;
        cipher_inc    = 1'b0;
        select_cipher = 1'b0;
        case (state)
            IDLE:
            begin
                busy      = 1'b0;
                text_init = start;
                if (start)
                    next_state = (cmd_wrap || cmd_verify) ? INIT_ENGINE : FAIL;
            end
            // empty region skips straight to padding
            INIT_ENGINE:
                if (eng.done)
                    next_state = mem_done ? PAD : READ_TEXT;
            READ_TEXT:
            begin
                mb_en      = 1'b1;
                ctr_inc    = 1'b1;
                next_state = ABSORB_TEXT;
            end
            ABSORB_TEXT:
                next_state = WAIT_TEXT;
            WAIT_TEXT:
                if (eng.done)
                begin
                    mb_en         = is_wrap;
                    mb_wr         = is_wrap;
                    select_cipher = is_wrap;
                    cipher_inc    = is_wrap;
                    data_out      = eng.out_word;
                    next_state    = mem_done ? PAD : READ_TEXT;
                end
            PAD:
                if (eng.done)
                begin
                    tag_init   = 1'b1;
                    next_state = SQUEEZE_TAG;
                end
            SQUEEZE_TAG:
                next_state = mem_done ? SUCCESS : WAIT_TAG;
            // wrap writes the tag word, verify reads the stored one
            WAIT_TAG:
                if (eng.done)
                begin
                    mb_en      = 1'b1;
                    mb_wr      = is_wrap;
                    ctr_inc    = is_wrap;
                    data_out   = eng.out_word;
                    next_state = is_wrap ? SQUEEZE_TAG : CHECK_TAG;
                end
            CHECK_TAG:
            begin
                ctr_inc    = 1'b1;
                next_state = (mem_in == eng.out_word) ? SQUEEZE_TAG : FAIL;
            end
            SUCCESS:
            begin
                reg_write  = 1'b1;
                data_out   = word_t'(1);
                next_state = IDLE;
            end
            FAIL:
            begin
                reg_write  = 1'b1;
                next_state = IDLE;
            end
            default:
                next_state = IDLE;
        endcase
    end

    // engine op goes out on entry to the state that waits for it
    assign issue = (next_state != state) &&
                   (next_state inside {INIT_ENGINE, WAIT_TEXT, PAD, WAIT_TAG});

    always_comb
        case (next_state)
            INIT_ENGINE: issue_op = OP_INIT;
            WAIT_TEXT:   issue_op = OP_ABSORB;
            PAD:         issue_op = OP_PAD;
            default:     issue_op = OP_SQUEEZE;
        endcase

    always_ff @(posedge clk)
        if (reset)
        begin
            state        <= IDLE;
            is_wrap      <= 1'b0;
            eng.op_valid <= 1'b0;
        end
        else
        begin
            state        <= next_state;
            eng.op_valid <= issue;
            if (state == IDLE && start)
                is_wrap <= cmd_wrap;
        end

    always_ff @(posedge clk)
        if (issue)
        begin
            eng.op   <= issue_op;
            eng.word <= mem_in;
        end

endmodule

`default_nettype wire

// File: crypto_golden.txt
# name cmd key words plain0..plain3 stored_tag0 stored_tag1
# cipher0..cipher3 tag0 tag1 result (region 0x0100, cipher 0x0200, tag 0x0300)
wrap4 wrap 01234567 4 1234 5678 9abc def0 0000 0000 ebd0 7cd5 a852 b4bb cb68 1f7f 1
verify_ok verify 01234567 4 1234 5678 9abc def0 cb68 1f7f 0000 0000 0000 0000 0000 0000 1
verify_bad1 verify 01234567 4 1234 5678 9abc def0 cb68 1f7e 0000 0000 0000 0000 0000 0000 0
verify_bad0 verify 01234567 4 1234 5678 9abc def0 4b68 1f7f 0000 0000 0000 0000 0000 0000 0
wrap_empty wrap 01234567 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 2811 0026 1

// File: crypto_pkg.sv
`default_nettype none

package crypto_pkg;

    // memory word, also the duplex rate
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    // rate in the upper half, capacity in the lower half
    typedef logic [31:0] dstate_t;
    typedef logic [31:0] key_t;

    typedef enum logic [1:0] {
        OP_INIT,
        OP_ABSORB,
        OP_PAD,
        OP_SQUEEZE
    } duplex_op_t;

    typedef enum logic [3:0] {
        IDLE,
        INIT_ENGINE,
        READ_TEXT,
        ABSORB_TEXT,
        WAIT_TEXT,
        PAD,
        SQUEEZE_TAG,
        WAIT_TAG,
        CHECK_TAG,
        SUCCESS,
        FAIL
    } ctrl_state_t;

    localparam int NUM_ROUNDS = 4;
    localparam dstate_t ROUND_CONST [NUM_ROUNDS] = '{
        32'h9e3779b9, 32'h7f4a7c15, 32'hf39cc060, 32'h5ced1f6b
    };

    localparam int WORD_BYTES = 2;
    localparam int TAG_WORDS  = 2;
    localparam int ROT_MIX    = 9;
    localparam int ROT_OUT    = 3;

endpackage

`default_nettype wire

// File: crypto_top.sv
`timescale 1ns/10ps
`default_nettype none

module crypto_top import crypto_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  cmd_wrap,
    input  logic  cmd_verify,
    input  key_t  key,
    input  addr_t region_start,
    input  addr_t region_end,
    input  addr_t cipher_start,
    input  addr_t tag_addr,
    input  word_t mem_in,
    output logic  busy,
    output logic  reg_write,
    output logic  mb_en,
    output logic  mb_wr,
    output addr_t mab,
    output word_t data_out
);

    logic text_init;
    logic tag_init;
    logic ctr_inc;
    logic cipher_inc;
    logic select_cipher;
    logic mem_done;

    // stage 0 is the absorb output, stage NUM_ROUNDS feeds the squeeze
    logic [NUM_ROUNDS:0] stage_valid;
    dstate_t             stage_state [NUM_ROUNDS+1];
    word_t               stage_word  [NUM_ROUNDS+1];
    dstate_t             held_state;

    duplex_if eng ();

    crypto_control control_i (.*);

    mem_walker walker_i (.*);

    duplex_absorb absorb_i (
        .clk, .reset, .eng, .key, .held_state,
        .out_valid (stage_valid[0]),
        .out_state (stage_state[0]),
        .out_word  (stage_word[0])
    );

    for (genvar i = 0; i < NUM_ROUNDS; i++)
    begin : g_round
        duplex_round round_i (
            .clk, .reset,
            .round_const (ROUND_CONST[i]),
            .in_valid    (stage_valid[i]),
            .in_state    (stage_state[i]),
            .in_word     (stage_word[i]),
            .out_valid   (stage_valid[i+1]),
            .out_state   (stage_state[i+1]),
            .out_word    (stage_word[i+1])
        );
    end

    duplex_squeeze squeeze_i (
        .clk, .reset, .eng, .held_state,
        .in_valid (stage_valid[NUM_ROUNDS]),
        .in_state (stage_state[NUM_ROUNDS]),
        .in_word  (stage_word[NUM_ROUNDS])
    );

endmodule

`default_nettype wire

// File: duplex_absorb.sv
`timescale 1ns/10ps
`default_nettype none

module duplex_absorb import crypto_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    duplex_if.feed  eng,
    input  key_t    key,
    input  dstate_t held_state,
    output logic    out_valid,
    output dstate_t out_state,
    output word_t   out_word
);

    word_t   rate;
    word_t   feed_word;
    dstate_t feed_state;

    assign rate = held_state[31:16];

    always_comb
    begin
        feed_word  = rate;
        feed_state = held_state;
        case (eng.op)
            OP_INIT:
            begin
                feed_word  = '0;
                feed_state = key;
            end
            OP_ABSORB:
            begin
                // ciphertext word doubles as the new rate
                feed_word  = eng.word ^ rate;
                feed_state = {feed_word, held_state[15:0]};
            end
            OP_PAD:
                feed_state = held_state ^ dstate_t'(1);
            OP_SQUEEZE:
                feed_state = held_state;
        endcase
    end

    always_ff @(posedge clk)
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= eng.op_valid;

    always_ff @(posedge clk)
        if (eng.op_valid)
        begin
            out_state <= feed_state;
            out_word  <= feed_word;
        end

endmodule

`default_nettype wire

// File: duplex_if.sv
`timescale 1ns/10ps
`default_nettype none

interface duplex_if import crypto_pkg::*; ();

    // request side
    logic       op_valid;
    duplex_op_t op;
    word_t      word;

    // result side, done pulses once per op
    logic       done;
    word_t      out_word;

    modport ctrl  (output op_valid, output op, output word, input done, input out_word);
    modport feed  (input op_valid, input op, input word);
    modport drain (output done, output out_word);

endinterface

`default_nettype wire

// File: duplex_round.sv
`timescale 1ns/10ps
`default_nettype none

module duplex_round import crypto_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  dstate_t round_const,
    input  logic    in_valid,
    input  dstate_t in_state,
    input  word_t   in_word,
    output logic    out_valid,
    output dstate_t out_state,
    output word_t   out_word
);

    dstate_t sum;
    dstate_t mixed;

    function automatic dstate_t rotl(input dstate_t x, input int n);
        return (x << n) | (x >> ($bits(dstate_t) - n));
    endfunction

    assign sum   = in_state + round_const;
    assign mixed = sum ^ rotl(sum, ROT_MIX);

    always_ff @(posedge clk)
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;

    // word rides along untouched
    always_ff @(posedge clk)
        if (in_valid)
        begin
            out_state <= rotl(mixed, ROT_OUT);
            out_word  <= in_word;
        end

endmodule

`default_nettype wire

// File: duplex_squeeze.sv
`timescale 1ns/10ps
`default_nettype none

module duplex_squeeze import crypto_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  dstate_t  in_state,
    input  word_t    in_word,
    duplex_if.drain  eng,
    output dstate_t  held_state
);

    always_ff @(posedge clk)
        if (reset)
            eng.done <= 1'b0;
        else
            eng.done <= in_valid;

    // state and result stay put until the next op arrives
    always_ff @(posedge clk)
        if (in_valid)
        begin
            held_state   <= in_state;
            eng.out_word <= in_word;
        end

endmodule

`default_nettype wire

// File: mem_walker.sv
`timescale 1ns/10ps
`default_nettype none

module mem_walker import crypto_pkg::*; (
    input  logic  clk,
    input  addr_t region_start,
    input  addr_t region_end,
    input  addr_t cipher_start,
    input  addr_t tag_addr,
    input  logic  text_init,
    input  logic  tag_init,
    input  logic  ctr_inc,
    input  logic  cipher_inc,
    input  logic  select_cipher,
    output addr_t mab,
    output logic  mem_done
);

    addr_t read_ctr;
    addr_t read_limit;
    addr_t cipher_ctr;

    always_ff @(posedge clk)
        if (text_init)
            read_ctr <= region_start;
        else if (tag_init)
            read_ctr <= tag_addr;
        else if (ctr_inc)
            read_ctr <= read_ctr + addr_t'(WORD_BYTES);

    always_ff @(posedge clk)
        if (text_init)
            read_limit <= region_end;
        else if (tag_init)
            read_limit <= tag_addr + addr_t'(TAG_WORDS * WORD_BYTES);

    always_ff @(posedge clk)
        if (text_init)
            cipher_ctr <= cipher_start;
        else if (cipher_inc)
            cipher_ctr <= cipher_ctr + addr_t'(WORD_BYTES);

    assign mem_done = read_ctr >= read_limit;
    assign mab      = select_cipher ? cipher_ctr : read_ctr;

endmodule

`default_nettype wire

// File: sim.f
crypto_pkg.sv
duplex_if.sv
duplex_absorb.sv
duplex_round.sv
duplex_squeeze.sv
mem_walker.sv
crypto_control.sv
crypto_top.sv
tb_crypto.sv

// File: tb_crypto.sv
`timescale 1ns/10ps
`default_nettype none

module tb_crypto import crypto_pkg::*; ();

    localparam int MAX_TESTS = 16;
    localparam int MAX_WORDS = 4;

    logic  clk;
    logic  reset;
    logic  start;
    logic  cmd_wrap;
    logic  cmd_verify;
    key_t  key;
    addr_t region_start;
    addr_t region_end;
    addr_t cipher_start;
    addr_t tag_addr;
    word_t mem_in;
    logic  busy;
    logic  reg_write;
    logic  mb_en;
    logic  mb_wr;
    addr_t mab;
    word_t data_out;

    // one entry per 16-bit word of the 64 KiB space
    word_t mem [0:32767];
    int    write_count;
    int    value_errors;
    int    other_errors;

    // golden vectors
    int    num_tests;
    string t_name [MAX_TESTS];
    logic  t_wrap [MAX_TESTS];
    key_t  t_key [MAX_TESTS];
    int    t_words [MAX_TESTS];
    word_t t_plain [MAX_TESTS][MAX_WORDS];
    word_t t_stored [MAX_TESTS][TAG_WORDS];
    word_t t_cipher [MAX_TESTS][MAX_WORDS];
    word_t t_tag [MAX_TESTS][TAG_WORDS];
    logic  t_result [MAX_TESTS];

    crypto_top dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // reads answer one cycle later and writes land at the edge
    always @(posedge clk)
    begin
        if (mb_en && mb_wr)
        begin
            mem[mab[15:1]] = data_out;
            write_count = write_count + 1;
        end
        else if (mb_en)
            mem_in <= #1 mem[mab[15:1]];
    end

    function automatic word_t fill_word(input int idx);
        addr_t a;
        a = addr_t'(idx * 2);
        return {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_result(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        string line;
        string name;
        string cmd;
        key_t  k;
        int    nw;
        word_t p0, p1, p2, p3, s0, s1, c0, c1, c2, c3, g0, g1;
        int    res;
        fd = $fopen("crypto_golden.txt", "r");
        num_tests = 0;
        if (fd == 0)
        begin
            $display("could not open the golden file crypto_golden.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS)
        begin
            line = "";
            if ($fgets(line, fd) == 0)
                continue;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %s %h %d %h %h %h %h %h %h %h %h %h %h %h %h %d",
                        name, cmd, k, nw, p0, p1, p2, p3, s0, s1,
                        c0, c1, c2, c3, g0, g1, res);
            if (n != 17)
            begin
                $display("malformed line in golden file: %s", line);
                other_errors++;
                continue;
            end
            t_name[num_tests]      = name;
            t_wrap[num_tests]      = (cmd == "wrap");
            t_key[num_tests]       = k;
            t_words[num_tests]     = nw;
            t_plain[num_tests]     = '{p0, p1, p2, p3};
            t_stored[num_tests]    = '{s0, s1};
            t_cipher[num_tests]    = '{c0, c1, c2, c3};
            t_tag[num_tests]       = '{g0, g1};
            t_result[num_tests]    = res[0];
            num_tests++;
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        int    k;
        word_t expected;
        string name;
        name = t_name[t];
        for (k = 0; k < 32768; k++)
            mem[k] = fill_word(k);
        for (k = 0; k < t_words[t]; k++)
            mem[(16'h0100 >> 1) + k] = t_plain[t][k];
        if (!t_wrap[t])
        begin
            mem[16'h0300 >> 1]       = t_stored[t][0];
            mem[(16'h0300 >> 1) + 1] = t_stored[t][1];
        end
        write_count = 0;

        @(posedge clk);
        #1;
        key          = t_key[t];
        region_start = 16'h0100;
        region_end   = addr_t'(16'h0100 + 2 * t_words[t]);
        cipher_start = 16'h0200;
        tag_addr     = 16'h0300;
        cmd_wrap     = t_wrap[t];
        cmd_verify   = !t_wrap[t];
        start        = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;

        // a second start with the other command must be ignored
        @(posedge clk);
        #1;
        check_result({name, " busy"}, 1'b1, busy);
        cmd_wrap   = !t_wrap[t];
        cmd_verify = t_wrap[t];
        start      = 1'b1;
        @(posedge clk);
        #1;
        start      = 1'b0;
        cmd_wrap   = t_wrap[t];
        cmd_verify = !t_wrap[t];

        @(negedge clk);
        while (!reg_write)
            @(negedge clk);
        check_result({name, " result"}, t_result[t], data_out[0]);
        check_word({name, " data_out"}, word_t'(t_result[t]), data_out);
        @(negedge clk);
        check_result({name, " busy after end"}, 1'b0, busy);

        for (k = 0; k < MAX_WORDS; k++)
        begin
            expected = (k < t_words[t]) ? t_plain[t][k] : fill_word((16'h0100 >> 1) + k);
            check_word($sformatf("%s plain%0d", name, k), expected, mem[(16'h0100 >> 1) + k]);
            expected = (t_wrap[t] && k < t_words[t]) ? t_cipher[t][k]
                                                     : fill_word((16'h0200 >> 1) + k);
            check_word($sformatf("%s cipher%0d", name, k), expected, mem[(16'h0200 >> 1) + k]);
        end
        for (k = 0; k < TAG_WORDS; k++)
        begin
            expected = t_wrap[t] ? t_tag[t][k] : t_stored[t][k];
            check_word($sformatf("%s tag%0d", name, k), expected, mem[(16'h0300 >> 1) + k]);
        end
        expected = t_wrap[t] ? word_t'(t_words[t] + TAG_WORDS) : '0;
        check_word({name, " write count"}, expected, word_t'(write_count));
    endtask

    initial
    begin
        int limit;
        reset        = 1'b1;
        start        = 1'b0;
        cmd_wrap     = 1'b0;
        cmd_verify   = 1'b0;
        key          = '0;
        region_start = '0;
        region_end   = '0;
        cipher_start = '0;
        tag_addr     = '0;
        mem_in       <= '0;
        write_count  = 0;
        value_errors = 0;
        other_errors = 0;

        load_golden();
        limit = num_tests * (6 + MAX_WORDS + 3) * (NUM_ROUNDS + 6) + 100;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout, the DUT did not finish within %0d cycles", limit);
                $display("TESTBENCH FAILED");
                $finish;
            end
        join_none

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_result("reset busy", 1'b0, busy);
        check_result("reset reg_write", 1'b0, reg_write);
        check_result("reset mb_en", 1'b0, mb_en);
        check_result("reset mb_wr", 1'b0, mb_wr);
        check_result("reset op_valid", 1'b0, dut_i.eng.op_valid);

        for (int t = 0; t < num_tests; t++)
            run_test(t);
        if (num_tests == 0)
        begin
            $display("no tests were read from the golden file");
            other_errors++;
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
